// File: calc_macros.svh
`ifndef CALC_MACROS_SVH
`define CALC_MACROS_SVH

// datapath widths

`define CALC_DATA_W 32 // operand and result width

`define CALC_CMD_W 4 // request command width

`define CALC_RESP_W 2 // response code width

// port count

`define CALC_NUM_PORTS 4 // request ports sharing the alu

// shifts take only the low bits of operand two

`define CALC_SHIFT_W 5 // shift amount bits

`endif

// File: calc_op_pkg.sv
`include "calc_macros.svh"

package calc_op_pkg;

	// command codes seen on reqN_cmd_in
	// any value not listed here is legal on the bus and decodes as invalid
	typedef enum logic [`CALC_CMD_W-1:0] {
		CMD_NOP = 4'h0, // no request
		CMD_ADD = 4'h1, // operand one plus operand two
		CMD_SUB = 4'h2, // operand one minus operand two
		CMD_SHL = 4'h5, // operand one shifted left
		CMD_SHR = 4'h6 // operand one shifted right
	} calc_cmd_e;

	// response codes driven on out_respN
	typedef enum logic [`CALC_RESP_W-1:0] {
		RESP_NONE = 2'd0, // nothing this cycle
		RESP_OK = 2'd1, // data is valid
		RESP_ERR = 2'd2, // add overflow or sub underflow
		RESP_INVALID = 2'd3 // unknown command
	} calc_resp_e;

endpackage

// File: calc_arb_pkg.sv
`include "calc_macros.svh"

package calc_arb_pkg;

	// port number, also the tag carried through the alu
	typedef logic [$clog2(`CALC_NUM_PORTS)-1:0] port_idx_t;

	// one bit per request port
	typedef logic [`CALC_NUM_PORTS-1:0] port_vec_t;

endpackage

// File: calc_arb_if.sv
`include "calc_macros.svh"

// one request port talking to the shared arbiter
interface calc_arb_if;
	import calc_op_pkg::*;

	logic req; // held until grant
	calc_cmd_e cmd;
	logic [`CALC_DATA_W-1:0] operand_a;
	logic [`CALC_DATA_W-1:0] operand_b;

	logic grant; // one cycle, same cycle as req
	logic rsp_valid; // one cycle pulse
	calc_resp_e rsp;
	logic [`CALC_DATA_W-1:0] rsp_data;

	modport port_mp (
		output req, cmd, operand_a, operand_b,
		input grant, rsp_valid, rsp, rsp_data
	);

	modport arb_mp (
		input req, cmd, operand_a, operand_b,
		output grant, rsp_valid, rsp, rsp_data
	);

endinterface

// File: calc_alu_if.sv
`include "calc_macros.svh"

// arbiter to alu, one op per cycle, result one cycle later with same tag
interface calc_alu_if;
	import calc_op_pkg::*;
	import calc_arb_pkg::*;

	logic op_valid;
	calc_cmd_e op;
	logic [`CALC_DATA_W-1:0] a;
	logic [`CALC_DATA_W-1:0] b;
	port_idx_t tag; // requesting port

	logic res_valid;
	calc_resp_e res;
	logic [`CALC_DATA_W-1:0] res_data;
	port_idx_t res_tag; // echoed tag

	modport arb_mp (
		output op_valid, op, a, b, tag,
		input res_valid, res, res_data, res_tag
	);

	modport alu_mp (
		input op_valid, op, a, b, tag,
		output res_valid, res, res_data, res_tag
	);

endinterface

// File: calc_port.sv
`include "calc_macros.svh"

module calc_port (
	input logic c_clk,
	input logic reset,
	input logic [`CALC_CMD_W-1:0] cmd_in,
	input logic [`CALC_DATA_W-1:0] data_in,
	output calc_op_pkg::calc_resp_e out_resp,
	output logic [`CALC_DATA_W-1:0] out_data,
	calc_arb_if.port_mp arb
);
	import calc_op_pkg::*;

	typedef enum logic [1:0] {
		ST_IDLE, // waiting for a command
		ST_GET_B, // operand two arrives this cycle
		ST_REQ, // asking the arbiter
		ST_WAIT // granted, result on its way
	} state_e;

	state_e state;
	state_e state_nxt;

	calc_cmd_e cmd_q;
	logic [`CALC_DATA_W-1:0] a_q;
	logic [`CALC_DATA_W-1:0] b_q;

	always_comb begin
		state_nxt = state;
		case (state)
			ST_IDLE: begin
				if (cmd_in != '0) begin // zero command is not a request
					state_nxt = ST_GET_B;
				end
			end
			ST_GET_B: begin
				state_nxt = ST_REQ;
			end
			ST_REQ: begin
				if (arb.grant) begin
					state_nxt = ST_WAIT;
				end
			end
			ST_WAIT: begin
				if (arb.rsp_valid) begin
					state_nxt = ST_IDLE;
				end
			end
			default: begin
				state_nxt = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge c_clk) begin
		if (reset) begin
			state <= ST_IDLE;
			out_resp <= RESP_NONE;
		end else begin
			state <= state_nxt;
			if (state == ST_WAIT && arb.rsp_valid) begin
				out_resp <= arb.rsp; // shown for exactly one cycle
			end else begin
				out_resp <= RESP_NONE;
			end
		end
	end

	// commands arriving while busy are dropped here
	always_ff @(posedge c_clk) begin
		if (state == ST_IDLE && cmd_in != '0) begin
			cmd_q <= calc_cmd_e'(cmd_in);
			a_q <= data_in; // operand one rides with the command
		end
		if (state == ST_GET_B) begin
			b_q <= data_in;
		end
		if (state == ST_WAIT && arb.rsp_valid) begin
			out_data <= arb.rsp_data;
		end
	end

	assign arb.req = (state == ST_REQ);
	assign arb.cmd = cmd_q;
	assign arb.operand_a = a_q;
	assign arb.operand_b = b_q;

endmodule

// File: calc_arbiter.sv
`include "calc_macros.svh"

module calc_arbiter (
	input logic c_clk,
	input logic reset,
	calc_arb_if.arb_mp ports [`CALC_NUM_PORTS],
	calc_alu_if.arb_mp alu
);
	import calc_op_pkg::*;
	import calc_arb_pkg::*;

	port_vec_t req_vec;
	port_vec_t gnt_vec;
	port_idx_t rr_ptr; // highest priority port this cycle
	port_idx_t gnt_idx;
	logic gnt_found;

	calc_cmd_e cmd_arr [`CALC_NUM_PORTS];
	logic [`CALC_DATA_W-1:0] a_arr [`CALC_NUM_PORTS];
	logic [`CALC_DATA_W-1:0] b_arr [`CALC_NUM_PORTS];

	for (genvar i = 0; i < `CALC_NUM_PORTS; i++) begin : g_port
		assign req_vec[i] = ports[i].req;
		assign cmd_arr[i] = ports[i].cmd;
		assign a_arr[i] = ports[i].operand_a;
		assign b_arr[i] = ports[i].operand_b;

		assign ports[i].grant = gnt_vec[i];
		// result goes back to whoever the tag names
		assign ports[i].rsp_valid = alu.res_valid && (alu.res_tag == port_idx_t'(i));
		assign ports[i].rsp = alu.res;
		assign ports[i].rsp_data = alu.res_data;
	end

	// search starts at rr_ptr and wraps
	always_comb begin
		port_idx_t cand;
		gnt_found = 1'b0;
		gnt_idx = rr_ptr;
		for (int k = 0; k < `CALC_NUM_PORTS; k++) begin
			cand = rr_ptr + port_idx_t'(k);
			if (!gnt_found && req_vec[cand]) begin
				gnt_found = 1'b1;
				gnt_idx = cand;
			end
		end
	end

	assign gnt_vec = gnt_found ? (port_vec_t'(1) << gnt_idx) : '0;

	always_ff @(posedge c_clk) begin
		if (reset) begin
			rr_ptr <= '0;
		end else if (gnt_found) begin
			rr_ptr <= gnt_idx + port_idx_t'(1); // winner drops to lowest priority
		end
	end

	assign alu.op_valid = gnt_found;
	assign alu.op = gnt_found ? cmd_arr[gnt_idx] : CMD_NOP;
	assign alu.a = a_arr[gnt_idx];
	assign alu.b = b_arr[gnt_idx];
	assign alu.tag = gnt_idx;

endmodule

// File: calc_alu.sv
`include "calc_macros.svh"

module calc_alu (
	input logic c_clk,
	input logic reset,
	calc_alu_if.alu_mp alu
);
	import calc_op_pkg::*;
	import calc_arb_pkg::*;

	logic [`CALC_DATA_W:0] sum; // extra bit is the carry out
	logic [`CALC_DATA_W:0] diff; // extra bit is the borrow
	logic [`CALC_SHIFT_W-1:0] shamt;

	calc_resp_e res_nxt;
	logic [`CALC_DATA_W-1:0] data_nxt;

	logic res_valid_q;
	calc_resp_e res_q;
	logic [`CALC_DATA_W-1:0] data_q;
	port_idx_t tag_q;

	assign sum = {1'b0, alu.a} + {1'b0, alu.b};
	assign diff = {1'b0, alu.a} - {1'b0, alu.b};
	assign shamt = alu.b[`CALC_SHIFT_W-1:0]; // upper bits of operand two ignored

	always_comb begin
		res_nxt = RESP_OK;
		data_nxt = '0;
		case (alu.op)
			CMD_ADD: begin
				if (sum[`CALC_DATA_W]) begin
					res_nxt = RESP_ERR; // overflow
				end else begin
					data_nxt = sum[`CALC_DATA_W-1:0];
				end
			end
			CMD_SUB: begin
				if (diff[`CALC_DATA_W]) begin
					res_nxt = RESP_ERR; // b > a
				end else begin
					data_nxt = diff[`CALC_DATA_W-1:0];
				end
			end
			CMD_SHL: data_nxt = alu.a << shamt;
			CMD_SHR: data_nxt = alu.a >> shamt;
			default: res_nxt = RESP_INVALID; // data stays zero
		endcase
	end

	always_ff @(posedge c_clk) begin
		if (reset) begin
			res_valid_q <= 1'b0;
		end else begin
			res_valid_q <= alu.op_valid;
		end
	end

	always_ff @(posedge c_clk) begin
		res_q <= res_nxt;
		data_q <= data_nxt;
		tag_q <= alu.tag;
	end

	assign alu.res_valid = res_valid_q;
	assign alu.res = res_q;
	assign alu.res_data = data_q;
	assign alu.res_tag = tag_q;

endmodule

// File: calc_top.sv
`include "calc_macros.svh"

module calc_top (
	input logic c_clk,
	input logic reset,
	input logic [`CALC_CMD_W-1:0] req1_cmd_in,
	input logic [`CALC_DATA_W-1:0] req1_data_in,
	input logic [`CALC_CMD_W-1:0] req2_cmd_in,
	input logic [`CALC_DATA_W-1:0] req2_data_in,
	input logic [`CALC_CMD_W-1:0] req3_cmd_in,
	input logic [`CALC_DATA_W-1:0] req3_data_in,
	input logic [`CALC_CMD_W-1:0] req4_cmd_in,
	input logic [`CALC_DATA_W-1:0] req4_data_in,
	output logic [`CALC_RESP_W-1:0] out_resp1,
	output logic [`CALC_DATA_W-1:0] out_data1,
	output logic [`CALC_RESP_W-1:0] out_resp2,
	output logic [`CALC_DATA_W-1:0] out_data2,
	output logic [`CALC_RESP_W-1:0] out_resp3,
	output logic [`CALC_DATA_W-1:0] out_data3,
	output logic [`CALC_RESP_W-1:0] out_resp4,
	output logic [`CALC_DATA_W-1:0] out_data4
);
	import calc_op_pkg::*;

	logic [`CALC_CMD_W-1:0] cmd_arr [`CALC_NUM_PORTS];
	logic [`CALC_DATA_W-1:0] din_arr [`CALC_NUM_PORTS];
	calc_resp_e resp_arr [`CALC_NUM_PORTS];
	logic [`CALC_DATA_W-1:0] dout_arr [`CALC_NUM_PORTS];

	calc_arb_if arb_if [`CALC_NUM_PORTS] ();
	calc_alu_if alu_if ();

	// index 0 is port 1
	assign cmd_arr[0] = req1_cmd_in;
	assign cmd_arr[1] = req2_cmd_in;
	assign cmd_arr[2] = req3_cmd_in;
	assign cmd_arr[3] = req4_cmd_in;
	assign din_arr[0] = req1_data_in;
	assign din_arr[1] = req2_data_in;
	assign din_arr[2] = req3_data_in;
	assign din_arr[3] = req4_data_in;

	assign out_resp1 = resp_arr[0];
	assign out_resp2 = resp_arr[1];
	assign out_resp3 = resp_arr[2];
	assign out_resp4 = resp_arr[3];
	assign out_data1 = dout_arr[0];
	assign out_data2 = dout_arr[1];
	assign out_data3 = dout_arr[2];
	assign out_data4 = dout_arr[3];

	for (genvar i = 0; i < `CALC_NUM_PORTS; i++) begin : g_port
		calc_port u_port (
			.c_clk(c_clk),
			.reset(reset),
			.cmd_in(cmd_arr[i]),
			.data_in(din_arr[i]),
			.out_resp(resp_arr[i]),
			.out_data(dout_arr[i]),
			.arb(arb_if[i])
		);
	end

	calc_arbiter u_arbiter (
		.c_clk(c_clk),
		.reset(reset),
		.ports(arb_if),
		.alu(alu_if)
	);

	calc_alu u_alu (
		.c_clk(c_clk),
		.reset(reset),
		.alu(alu_if)
	);

endmodule

// File: calc_assert.sv
`include "calc_macros.svh"

module calc_assert (
	input logic c_clk,
	input logic reset,
	input logic [`CALC_CMD_W-1:0] req1_cmd_in, req2_cmd_in, req3_cmd_in, req4_cmd_in,
	input logic [`CALC_RESP_W-1:0] out_resp1, out_resp2, out_resp3, out_resp4,
	input logic [`CALC_DATA_W-1:0] out_data1, out_data2, out_data3, out_data4
);
	timeunit 1ns;
	timeprecision 100ps;
	import calc_op_pkg::*;

	logic [3:0][`CALC_RESP_W-1:0] resp;
	logic [3:0][`CALC_DATA_W-1:0] data;
	logic cmd_seen; // any command since reset

	assign resp = {out_resp4, out_resp3, out_resp2, out_resp1};
	assign data = {out_data4, out_data3, out_data2, out_data1};

	always_ff @(posedge c_clk) begin
		if (reset) begin
			cmd_seen <= 1'b0;
		end else if ((req1_cmd_in | req2_cmd_in | req3_cmd_in | req4_cmd_in) != '0) begin
			cmd_seen <= 1'b1;
		end
	end

	for (genvar i = 0; i < `CALC_NUM_PORTS; i++) begin : g_chk
		one_cycle: assert property (@(posedge c_clk) disable iff (reset)
			resp[i] != '0 |=> resp[i] == '0)
			else $error("port %0d response held past one cycle", i + 1);
		err_no_data: assert property (@(posedge c_clk) disable iff (reset)
			(resp[i] == RESP_ERR || resp[i] == RESP_INVALID) |-> data[i] == '0)
			else $error("port %0d error response carries data", i + 1);
		quiet_after_reset: assert property (@(posedge c_clk) disable iff (reset)
			!cmd_seen |-> resp[i] == '0)
			else $error("port %0d responded before any command", i + 1);
	end

endmodule

bind calc_top calc_assert u_assert (.*);

// File: calc_tb.sv
`include "calc_macros.svh"

module calc_tb;
	timeunit 1ns;
	timeprecision 100ps;
	import calc_op_pkg::*;

	localparam int WAIT_LIMIT = 12; // cycles to wait for one response
	localparam int TIMEOUT_CYCLES = 20000; // the whole run needs about 8000
	localparam logic [3:0] OP_LIST [6] = '{CMD_ADD, CMD_SUB, CMD_SHL, CMD_SHR, 4'h3, 4'hc};

	logic c_clk = 1'b0;
	logic reset;
	logic [`CALC_CMD_W-1:0] cmd_in [4];
	logic [`CALC_DATA_W-1:0] data_in [4];
	logic [`CALC_RESP_W-1:0] resp_out [4];
	logic [`CALC_DATA_W-1:0] data_out [4];
	integer seed = 32'hfa13;
	int errors = 0;
	int checks = 0;
	int cycles = 0;

	calc_top uut (
		.c_clk(c_clk),
		.reset(reset),
		.req1_cmd_in(cmd_in[0]), .req1_data_in(data_in[0]),
		.req2_cmd_in(cmd_in[1]), .req2_data_in(data_in[1]),
		.req3_cmd_in(cmd_in[2]), .req3_data_in(data_in[2]),
		.req4_cmd_in(cmd_in[3]), .req4_data_in(data_in[3]),
		.out_resp1(resp_out[0]), .out_data1(data_out[0]),
		.out_resp2(resp_out[1]), .out_data2(data_out[1]),
		.out_resp3(resp_out[2]), .out_data3(data_out[2]),
		.out_resp4(resp_out[3]), .out_data4(data_out[3])
	);

	always #2 c_clk = ~c_clk;

	always @(posedge c_clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the tests did not finish", cycles);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// expected {response, data} for one command
	function automatic logic [33:0] model_result(logic [3:0] c, logic [31:0] a, logic [31:0] b);
		case (c)
			CMD_ADD: return (a > 32'hffff_ffff - b) ? {RESP_ERR, 32'h0} : {RESP_OK, a + b}; // too big
			CMD_SUB: return (b > a) ? {RESP_ERR, 32'h0} : {RESP_OK, a - b};
			CMD_SHL: return {RESP_OK, a << b[4:0]};
			CMD_SHR: return {RESP_OK, a >> b[4:0]};
			default: return {RESP_INVALID, 32'h0};
		endcase
	endfunction

	task automatic check_val(string name, logic [31:0] expected, logic [31:0] actual);
		checks++;
		if (actual !== expected) begin
			errors++;
			$display("ERROR %s: expected 0x%h, got 0x%h", name, expected, actual);
		end
	endtask

	task automatic check_resp(int p, logic [33:0] want, logic [1:0] r, logic [31:0] d);
		check_val($sformatf("out_resp%0d", p + 1), 32'(want[33:32]), 32'(r));
		check_val($sformatf("out_data%0d", p + 1), want[31:0], d);
	endtask

	// command with operand one, then operand two under a zero command
	task automatic send_cmd(int p, logic [3:0] c, logic [31:0] a, logic [31:0] b);
		@(posedge c_clk);
		cmd_in[p] <= c;
		data_in[p] <= a;
		@(posedge c_clk);
		cmd_in[p] <= '0;
		data_in[p] <= b;
	endtask

	task automatic wait_resp(int p, logic [33:0] want);
		int n;
		n = 0;
		do begin
			@(negedge c_clk); // outputs are settled here
			n++;
		end while (resp_out[p] == '0 && n < WAIT_LIMIT);
		if (resp_out[p] == '0) begin
			errors++;
			$display("no response came on port %0d within %0d cycles", p + 1, WAIT_LIMIT);
		end else begin
			check_resp(p, want, resp_out[p], data_out[p]);
		end
	endtask

	task automatic run_op(int p, logic [3:0] c, logic [31:0] a, logic [31:0] b);
		send_cmd(p, c, a, b);
		wait_resp(p, model_result(c, a, b));
	endtask

	task automatic expect_quiet(int p);
		repeat (WAIT_LIMIT) begin
			@(negedge c_clk);
			if (resp_out[p] != '0) begin
				errors++;
				$display("port %0d gave a response where none was due", p + 1);
			end
		end
	endtask

	task automatic test_codes();
		for (int p = 0; p < 4; p++) begin
			send_cmd(p, CMD_NOP, 32'h5, 32'h6);
			expect_quiet(p);
			run_op(p, CMD_ADD, 32'h1234, 32'h4321);
			run_op(p, CMD_ADD, 32'hffff_ffff, 32'h1);
			run_op(p, 4'h3, 32'h7, 32'h8);
		end
	endtask

	task automatic test_arith();
		for (int p = 0; p < 4; p++) begin
			run_op(p, CMD_ADD, 32'h1357_9bdf, 32'h0246_8ace);
			run_op(p, CMD_SUB, 32'h9000_0000, 32'h1234_5678);
			run_op(p, CMD_SHL, 32'h0000_f00d, 32'h8);
			run_op(p, CMD_SHR, 32'hf00d_0000, 32'h10);
		end
	endtask

	task automatic test_corners();
		for (int p = 0; p < 4; p++) begin
			run_op(p, CMD_ADD, 32'hffff_fffe, 32'h2); // one past the top
			run_op(p, CMD_ADD, 32'hffff_0000, 32'h0000_ffff);
			run_op(p, CMD_SUB, 32'h8765_4321, 32'h8765_4321);
			run_op(p, CMD_SUB, 32'h41, 32'h42);
			run_op(p, CMD_SHL, 32'hdead_beef, 32'h0);
			run_op(p, CMD_SHR, 32'hdead_beef, 32'h0);
			run_op(p, CMD_SHL, 32'h1, 32'd31);
			run_op(p, CMD_SHR, 32'h8000_0000, 32'd31);
			run_op(p, CMD_SHL, 32'h5, 32'h21); // only the low five bits count
			run_op(p, CMD_SHR, 32'ha, 32'h21);
		end
	endtask

	// all four ports fire in the same cycle
	task automatic test_concurrent(int rounds);
		logic [3:0] c [4];
		logic [31:0] a [4];
		logic [31:0] b [4];
		logic [33:0] want [4];
		int seen [4];
		repeat (rounds) begin
			@(posedge c_clk);
			for (int p = 0; p < 4; p++) begin
				c[p] = OP_LIST[$unsigned($random(seed)) % 4];
				a[p] = $random(seed);
				b[p] = $random(seed);
				want[p] = model_result(c[p], a[p], b[p]);
				seen[p] = 0;
				cmd_in[p] <= c[p];
				data_in[p] <= a[p];
			end
			@(posedge c_clk);
			for (int p = 0; p < 4; p++) begin
				cmd_in[p] <= '0;
				data_in[p] <= b[p];
			end
			for (int n = 1; n <= WAIT_LIMIT; n++) begin
				@(negedge c_clk); // n - 1 edges since the command was sampled
				for (int p = 0; p < 4; p++) begin
					if (resp_out[p] != '0) begin
						seen[p]++;
						check_resp(p, want[p], resp_out[p], data_out[p]);
						if (n - 1 > 6) begin
							errors++;
							$display("port %0d answered %0d edges after its command", p + 1, n - 1);
						end
					end
				end
			end
			for (int p = 0; p < 4; p++) begin
				if (seen[p] != 1) begin
					errors++;
					$display("port %0d gave %0d responses to one command", p + 1, seen[p]);
				end
			end
		end
	endtask

	task automatic test_random(int count);
		int p;
		logic [3:0] c;
		logic [31:0] a;
		logic [31:0] b;
		repeat (count) begin
			p = $unsigned($random(seed)) % 4;
			c = OP_LIST[$unsigned($random(seed)) % 6];
			a = $random(seed);
			b = $random(seed);
			run_op(p, c, a, b);
		end
	endtask

	task automatic test_busy();
		for (int p = 0; p < 4; p++) begin
			send_cmd(p, CMD_ADD, 32'h100, 32'h23);
			send_cmd(p, CMD_SUB, 32'h9, 32'h4); // lands while the port is requesting
			wait_resp(p, model_result(CMD_ADD, 32'h100, 32'h23));
			expect_quiet(p);
			run_op(p, CMD_SHL, 32'h3, 32'h4);
		end
	endtask

	initial begin
		reset <= 1'b1;
		for (int p = 0; p < 4; p++) begin
			cmd_in[p] <= '0;
			data_in[p] <= '0;
		end
		repeat (3) @(posedge c_clk);
		reset <= 1'b0;
		test_codes();
		test_arith();
		test_corners();
		test_concurrent(20);
		test_random(1000);
		test_busy();
		repeat (2) @(posedge c_clk);
		$display("run over after %0d cycles, %0d checks, %0d errors", cycles, checks, errors);
		if (errors == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

// File: filelist.f
+incdir+.
calc_op_pkg.sv
calc_arb_pkg.sv
calc_arb_if.sv
calc_alu_if.sv
calc_port.sv
calc_arbiter.sv
calc_alu.sv
calc_top.sv
calc_assert.sv
calc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the calculator testbench with verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
	-f filelist.f --top-module calc_tb -o calc_sim
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/calc_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "ALL TESTS PASSED" "$log"; then
	exit 0
fi
echo "pass message not found in $log"
exit 1
